//--- hw/storeQueuePkg.sv
//********************
// Store queue shared definitions
// Widths, access size encoding and the
// byte mask and lane alignment helpers
//********************
`default_nettype none

package storeQueuePkg;

    // Physical address and store data widths
    localparam int paddrWidth = 56;
    localparam int dataWidth  = 64;

    // One doubleword lane, one mask bit per byte
    localparam int laneBytes = 8;

    // Access size, 2^size bytes
    typedef enum logic [1:0] {
        sizeByte   = 2'd0,
        sizeHalf   = 2'd1,
        sizeWord   = 2'd2,
        sizeDouble = 2'd3
    } accessSize;

    // Lane mask for an aligned access at the given offset
    function automatic logic [laneBytes-1:0] sizeMask(input logic [2:0] offset,
                                                     input accessSize size);
        logic [laneBytes-1:0] base;
        case (size)
            sizeByte:   base = 8'h01;
            sizeHalf:   base = 8'h03;
            sizeWord:   base = 8'h0f;
            default:    base = 8'hff;
        endcase
        return base << offset;
    endfunction

    // Low-held store data moved up into its byte lanes
    function automatic logic [dataWidth-1:0] laneAlign(input logic [dataWidth-1:0] data,
                                                      input logic [2:0] offset);
        return data << {offset, 3'b000};
    endfunction

endpackage

`default_nettype wire

//--- hw/storeAlloc.sv
//********************
// Store allocation
// Owns the tail pointer, accepts stores
// and forms the byte mask of each one
//********************
`timescale 1ns/1ns
`default_nettype none

module storeAlloc #(
    parameter int sqDepth = 8
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      wrValid,
    input  wire                                      stall,
    input  wire                                      flush,
    input  wire [storeQueuePkg::paddrWidth-1:0]      wrPaddr,
    input  storeQueuePkg::accessSize                 wrSize,
    output logic                                     allocStrobe,
    output logic [$clog2(sqDepth)-1:0]               allocIdx,
    output logic [storeQueuePkg::laneBytes-1:0]      allocMask,
    output logic [$clog2(sqDepth)-1:0]               sqIndex
);
    import storeQueuePkg::*;

    localparam int idxWidth = $clog2(sqDepth);

    // Next free slot
    logic [idxWidth-1:0] tailPtr;

    // Stall or flush refuses the write, no back-pressure to upstream
    assign allocStrobe = wrValid && !stall && !flush;

    // Store lands at the tail
    assign allocIdx = tailPtr;

    // Aligned access, so the mask never leaves this doubleword
    assign allocMask = sizeMask(wrPaddr[2:0], wrSize);

    // Index handed to the commit stage
    assign sqIndex = tailPtr;

    // Power-of-two depth wraps by overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            tailPtr <= '0;
        end else if (allocStrobe) begin
            tailPtr <= tailPtr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/storeEntries.sv
//********************
// Store entry array
// Holds every store with its valid, retired
// and killed state, applies retire, flush,
// drain and write updates, and tracks the
// head pointer and occupancy
//********************
`timescale 1ns/1ns
`default_nettype none

module storeEntries #(
    parameter int sqDepth = 8
) (
    input  wire                                                     clk,
    input  wire                                                     rst,
    input  wire                                                     flush,
    input  wire                                                     allocStrobe,
    input  wire [$clog2(sqDepth)-1:0]                               allocIdx,
    input  wire [storeQueuePkg::laneBytes-1:0]                      allocMask,
    input  wire [storeQueuePkg::paddrWidth-1:0]                     wrPaddr,
    input  storeQueuePkg::accessSize                                wrSize,
    input  wire [storeQueuePkg::dataWidth-1:0]                      wrData,
    input  wire                                                     retireValid,
    input  wire [$clog2(sqDepth)-1:0]                               retireIdx,
    input  wire                                                     drainDone,
    output logic                                                    headValid,
    output logic                                                    headRetired,
    output logic                                                    headKilled,
    output logic [storeQueuePkg::paddrWidth-1:0]                    headPaddr,
    output storeQueuePkg::accessSize                                headSize,
    output logic [storeQueuePkg::dataWidth-1:0]                     headData,
    output logic [sqDepth-1:0]                                      entryValid,
    output logic [sqDepth-1:0][storeQueuePkg::paddrWidth-1:0]       entryPaddr,
    output logic [sqDepth-1:0][storeQueuePkg::dataWidth-1:0]        entryData,
    output logic [sqDepth-1:0][storeQueuePkg::laneBytes-1:0]        entryMask,
    output logic [$clog2(sqDepth)-1:0]                              headIdx,
    output logic [$clog2(sqDepth):0]                                usedEntries,
    output logic [$clog2(sqDepth):0]                                freeEntries
);
    import storeQueuePkg::*;

    localparam int idxWidth = $clog2(sqDepth);
    localparam int cntWidth = idxWidth + 1;

    // Per-entry state beyond the exported arrays
    logic [sqDepth-1:0] entryRetired;
    logic [sqDepth-1:0] entryKilled;
    accessSize          entrySize [sqDepth];

    //********************
    // Entry state
    //********************
    // Later statements override earlier ones, so the order sets priority
    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid   <= '0;
            entryRetired <= '0;
            entryKilled  <= '0;
        end else begin
            for (int i = 0; i < sqDepth; i++) begin
                // Retire only live, not yet retired entries
                if (retireValid && retireIdx == idxWidth'(i) &&
                    entryValid[i] && !entryRetired[i]) begin
                    entryRetired[i] <= 1'b1;
                end
                // Flush beats a retire in the same cycle
                if (flush && entryValid[i] && !entryRetired[i]) begin
                    entryValid[i]   <= 1'b0;
                    entryRetired[i] <= 1'b0;
                    entryKilled[i]  <= 1'b1;
                end
            end
            // Head written out or skipped
            if (drainDone) begin
                entryValid[headIdx]   <= 1'b0;
                entryRetired[headIdx] <= 1'b0;
                entryKilled[headIdx]  <= 1'b0;
            end
            // New store
            if (allocStrobe) begin
                entryValid[allocIdx]   <= 1'b1;
                entryRetired[allocIdx] <= 1'b0;
                entryKilled[allocIdx]  <= 1'b0;
            end
        end
    end

    // Store payload
    always_ff @(posedge clk) begin
        if (allocStrobe) begin
            entryPaddr[allocIdx] <= wrPaddr;
            entrySize[allocIdx]  <= wrSize;
            entryData[allocIdx]  <= wrData;
            entryMask[allocIdx]  <= allocMask;
        end
    end

    //********************
    // Head and occupancy
    //********************
    always_ff @(posedge clk) begin
        if (rst) begin
            headIdx     <= '0;
            usedEntries <= '0;
        end else begin
            if (drainDone) begin
                headIdx <= headIdx + 1'b1;
            end
            case ({allocStrobe, drainDone})
                2'b10:   usedEntries <= usedEntries + 1'b1;
                2'b01:   usedEntries <= usedEntries - 1'b1;
                default: usedEntries <= usedEntries;
            endcase
        end
    end

    assign freeEntries = cntWidth'(sqDepth) - usedEntries;

    // Oldest entry seen by the drain
    assign headValid   = entryValid[headIdx];
    assign headRetired = entryRetired[headIdx];
    assign headKilled  = entryKilled[headIdx];
    assign headPaddr   = entryPaddr[headIdx];
    assign headSize    = entrySize[headIdx];
    assign headData    = entryData[headIdx];

endmodule

`default_nettype wire

//--- hw/storeDrain.sv
//********************
// Store drain
// Sends retired head stores to the D-cache
// write port in order, skips killed heads
//********************
`timescale 1ns/1ns
`default_nettype none

module storeDrain (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      headValid,
    input  wire                                      headRetired,
    input  wire                                      headKilled,
    input  wire [storeQueuePkg::paddrWidth-1:0]      headPaddr,
    input  storeQueuePkg::accessSize                 headSize,
    input  wire [storeQueuePkg::dataWidth-1:0]       headData,
    input  wire                                      dcReady,
    input  wire                                      dcDone,
    output logic                                     drainDone,
    output logic                                     dcReqValid,
    output logic [storeQueuePkg::paddrWidth-1:0]     dcReqPaddr,
    output storeQueuePkg::accessSize                 dcReqSize,
    output logic [storeQueuePkg::dataWidth-1:0]      dcReqData
);
    import storeQueuePkg::*;

    // High while a D-cache write is outstanding
    logic busy;

    // Idle, head ready to go out and cache accepting
    logic startReq;

    // Idle and head was flushed away
    logic skipHead;

    assign startReq = !busy && headValid && headRetired && dcReady;
    assign skipHead = !busy && !headValid && headKilled;

    // Completion or skip frees the head in this cycle
    assign drainDone = skipHead || (busy && dcDone);

    // Request valid is the busy flag itself
    assign dcReqValid = busy;

    //********************
    // Busy / idle FSM
    //********************
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (startReq) begin
            busy <= 1'b1;
        end else if (busy && dcDone) begin
            busy <= 1'b0;
        end
    end

    // Request fields captured once, stable until done
    always_ff @(posedge clk) begin
        if (startReq) begin
            dcReqPaddr <= headPaddr;
            dcReqSize  <= headSize;
            dcReqData  <= headData;
        end
    end

endmodule

`default_nettype wire

//--- hw/loadForward.sv
//********************
// Load forwarding
// Merges store bytes into a load, oldest
// first, so the youngest match wins a byte
//********************
`timescale 1ns/1ns
`default_nettype none

module loadForward #(
    parameter int sqDepth = 8
) (
    input  wire                                                     ldValid,
    input  wire [storeQueuePkg::paddrWidth-1:0]                     ldPaddr,
    input  wire [storeQueuePkg::laneBytes-1:0]                      ldByteMask,
    input  wire [sqDepth-1:0]                                       entryValid,
    input  wire [sqDepth-1:0][storeQueuePkg::paddrWidth-1:0]        entryPaddr,
    input  wire [sqDepth-1:0][storeQueuePkg::dataWidth-1:0]         entryData,
    input  wire [sqDepth-1:0][storeQueuePkg::laneBytes-1:0]         entryMask,
    input  wire [$clog2(sqDepth)-1:0]                               headIdx,
    output logic                                                    ldRespValid,
    output logic [storeQueuePkg::laneBytes-1:0]                     ldMatchMask,
    output logic [storeQueuePkg::dataWidth-1:0]                     ldData
);
    import storeQueuePkg::*;

    localparam int idxWidth = $clog2(sqDepth);

    // Entry visited at each age step, 0 is the oldest
    logic [idxWidth-1:0]  ageIdx [sqDepth];

    // Bytes this entry supplies to the load
    logic [laneBytes-1:0] hitMask [sqDepth];

    // Entry data moved into doubleword lanes
    logic [dataWidth-1:0] laneData [sqDepth];

    for (genvar g = 0; g < sqDepth; g++) begin : gAge
        // Walk from the head, wraps on the power-of-two depth
        assign ageIdx[g] = headIdx + idxWidth'(g);

        // Same doubleword and overlapping bytes
        assign hitMask[g] = (entryValid[ageIdx[g]] &&
                             entryPaddr[ageIdx[g]][paddrWidth-1:3] == ldPaddr[paddrWidth-1:3])
                            ? (entryMask[ageIdx[g]] & ldByteMask) : '0;

        assign laneData[g] = laneAlign(entryData[ageIdx[g]], entryPaddr[ageIdx[g]][2:0]);
    end

    //********************
    // Byte merge
    //********************
    // Younger entries come later and overwrite older bytes
    always_comb begin
        ldMatchMask = '0;
        ldData      = '0;
        for (int j = 0; j < sqDepth; j++) begin
            ldMatchMask = ldMatchMask | hitMask[j];
            for (int k = 0; k < laneBytes; k++) begin
                if (hitMask[j][k]) begin
                    ldData[k*8 +: 8] = laneData[j][k*8 +: 8];
                end
            end
        end
    end

    // Same-cycle response
    assign ldRespValid = ldValid;

endmodule

`default_nettype wire

//--- hw/storeQueue.sv
//********************
// Store queue top level
// Allocation, entry array, D-cache drain
// and load forwarding wired together
//********************
`timescale 1ns/1ns
`default_nettype none

module storeQueue #(
    parameter int sqDepth = 8
) (
    input  wire                                      clk,
    input  wire                                      rst,
    // Store write port
    input  wire                                      wrValid,
    input  wire                                      stall,
    input  wire                                      flush,
    input  wire [storeQueuePkg::paddrWidth-1:0]      wrPaddr,
    input  storeQueuePkg::accessSize                 wrSize,
    input  wire [storeQueuePkg::dataWidth-1:0]       wrData,
    output logic [$clog2(sqDepth)-1:0]               sqIndex,
    // Retire port
    input  wire                                      retireValid,
    input  wire [$clog2(sqDepth)-1:0]                retireIdx,
    // Load forwarding port
    input  wire                                      ldValid,
    input  wire [storeQueuePkg::paddrWidth-1:0]      ldPaddr,
    input  wire [storeQueuePkg::laneBytes-1:0]       ldByteMask,
    output logic                                     ldRespValid,
    output logic [storeQueuePkg::laneBytes-1:0]      ldMatchMask,
    output logic [storeQueuePkg::dataWidth-1:0]      ldData,
    // D-cache write port
    input  wire                                      dcReady,
    input  wire                                      dcDone,
    output logic                                     dcReqValid,
    output logic [storeQueuePkg::paddrWidth-1:0]     dcReqPaddr,
    output storeQueuePkg::accessSize                 dcReqSize,
    output logic [storeQueuePkg::dataWidth-1:0]      dcReqData,
    // Occupancy
    output logic [$clog2(sqDepth):0]                 usedEntries,
    output logic [$clog2(sqDepth):0]                 freeEntries
);
    import storeQueuePkg::*;

    localparam int idxWidth = $clog2(sqDepth);

    // Allocation to entry array
    logic                 allocStrobe;
    logic [idxWidth-1:0]  allocIdx;
    logic [laneBytes-1:0] allocMask;

    // Head entry and drain handshake
    logic                 headValid;
    logic                 headRetired;
    logic                 headKilled;
    logic [paddrWidth-1:0] headPaddr;
    accessSize            headSize;
    logic [dataWidth-1:0] headData;
    logic                 drainDone;

    // Entry arrays for forwarding
    logic [sqDepth-1:0]                  entryValid;
    logic [sqDepth-1:0][paddrWidth-1:0]  entryPaddr;
    logic [sqDepth-1:0][dataWidth-1:0]   entryData;
    logic [sqDepth-1:0][laneBytes-1:0]   entryMask;
    logic [idxWidth-1:0]                 headIdx;

    storeAlloc #(.sqDepth(sqDepth)) i_storeAlloc (
        .clk         (clk),
        .rst         (rst),
        .wrValid     (wrValid),
        .stall       (stall),
        .flush       (flush),
        .wrPaddr     (wrPaddr),
        .wrSize      (wrSize),
        .allocStrobe (allocStrobe),
        .allocIdx    (allocIdx),
        .allocMask   (allocMask),
        .sqIndex     (sqIndex)
    );

    storeEntries #(.sqDepth(sqDepth)) i_storeEntries (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .allocStrobe (allocStrobe),
        .allocIdx    (allocIdx),
        .allocMask   (allocMask),
        .wrPaddr     (wrPaddr),
        .wrSize      (wrSize),
        .wrData      (wrData),
        .retireValid (retireValid),
        .retireIdx   (retireIdx),
        .drainDone   (drainDone),
        .headValid   (headValid),
        .headRetired (headRetired),
        .headKilled  (headKilled),
        .headPaddr   (headPaddr),
        .headSize    (headSize),
        .headData    (headData),
        .entryValid  (entryValid),
        .entryPaddr  (entryPaddr),
        .entryData   (entryData),
        .entryMask   (entryMask),
        .headIdx     (headIdx),
        .usedEntries (usedEntries),
        .freeEntries (freeEntries)
    );

    storeDrain i_storeDrain (
        .clk         (clk),
        .rst         (rst),
        .headValid   (headValid),
        .headRetired (headRetired),
        .headKilled  (headKilled),
        .headPaddr   (headPaddr),
        .headSize    (headSize),
        .headData    (headData),
        .dcReady     (dcReady),
        .dcDone      (dcDone),
        .drainDone   (drainDone),
        .dcReqValid  (dcReqValid),
        .dcReqPaddr  (dcReqPaddr),
        .dcReqSize   (dcReqSize),
        .dcReqData   (dcReqData)
    );

    loadForward #(.sqDepth(sqDepth)) i_loadForward (
        .ldValid     (ldValid),
        .ldPaddr     (ldPaddr),
        .ldByteMask  (ldByteMask),
        .entryValid  (entryValid),
        .entryPaddr  (entryPaddr),
        .entryData   (entryData),
        .entryMask   (entryMask),
        .headIdx     (headIdx),
        .ldRespValid (ldRespValid),
        .ldMatchMask (ldMatchMask),
        .ldData      (ldData)
    );

endmodule

`default_nettype wire

//--- tb/tbStoreQueue.sv
//********************
// Store queue testbench
// Directed tests for write, retire, flush,
// D-cache drain and load forwarding against
// a small queue model of live stores
//********************
`timescale 1ns/1ns
`default_nettype none

module tbStoreQueue;
    import storeQueuePkg::*;

    localparam int  sqDepth       = 8;
    localparam int  numTests      = 5;
    localparam int  cyclesPerTest = 200;
    localparam time clkPeriod     = 8;
    localparam int  waitBound     = 20;

    // DUT signals
    logic                  clk;
    logic                  rst;
    logic                  wrValid;
    logic                  stall;
    logic                  flush;
    logic [paddrWidth-1:0] wrPaddr;
    accessSize             wrSize;
    logic [dataWidth-1:0]  wrData;
    logic [2:0]            sqIndex;
    logic                  retireValid;
    logic [2:0]            retireIdx;
    logic                  ldValid;
    logic [paddrWidth-1:0] ldPaddr;
    logic [laneBytes-1:0]  ldByteMask;
    logic                  ldRespValid;
    logic [laneBytes-1:0]  ldMatchMask;
    logic [dataWidth-1:0]  ldData;
    logic                  dcReady;
    logic                  dcDone;
    logic                  dcReqValid;
    logic [paddrWidth-1:0] dcReqPaddr;
    accessSize             dcReqSize;
    logic [dataWidth-1:0]  dcReqData;
    logic [3:0]            usedEntries;
    logic [3:0]            freeEntries;

    // Live stores in write order with flushed ones removed
    logic [paddrWidth-1:0] mPaddr [$];
    accessSize             mSize [$];
    logic [dataWidth-1:0]  mData [$];
    int                    mIdx [$];
    bit                    mRetired [$];
    int                    modelTail;

    int    seed = 32'h1b92_9cfb;
    int    errorCount;
    int    testCount;
    int    failedTests;
    int    reqCount;
    logic  prevReqValid;
    string curTest;

    storeQueue #(.sqDepth(sqDepth)) i_storeQueue (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Watchdog sized from the test count
    initial begin
        #(numTests * cyclesPerTest * clkPeriod);
        $display("Watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    // Request starts seen on the D-cache port
    always @(posedge clk) begin
        if (!rst && dcReqValid && !prevReqValid) begin
            reqCount++;
        end
        prevReqValid <= dcReqValid;
    end

    //********************
    // Helpers
    //********************
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED %s %s: expected %h, actual %h", curTest, what, expected, actual);
        end
    endtask

    task automatic reportError(input string msg);
        errorCount++;
        $display("Error in %s: %s", curTest, msg);
    endtask

    task automatic endTest(input int errorsBefore);
        testCount++;
        if (errorCount != errorsBefore) begin
            failedTests++;
        end
        $display("Test %s finished with %0d errors", curTest, errorCount - errorsBefore);
    endtask

    task automatic writeStore(input logic [paddrWidth-1:0] paddr, input accessSize size,
                              input logic [dataWidth-1:0] data);
        checkValue("sqIndex", modelTail, sqIndex);
        wrValid = 1'b1;
        wrPaddr = paddr;
        wrSize  = size;
        wrData  = data;
        stepCycle();
        wrValid = 1'b0;
        mPaddr.push_back(paddr);
        mSize.push_back(size);
        mData.push_back(data);
        mIdx.push_back(modelTail);
        mRetired.push_back(1'b0);
        modelTail = (modelTail + 1) % sqDepth;
    endtask

    // Random size with the address aligned to it
    task automatic writeRandomStore();
        accessSize             size;
        logic [paddrWidth-1:0] paddr;
        size  = accessSize'($random(seed) & 3);
        paddr = {$random(seed), $random(seed)};
        paddr[2:0] = paddr[2:0] & ~3'((1 << size) - 1);
        writeStore(paddr, size, {$random(seed), $random(seed)});
    endtask

    task automatic retireStore(input int idx);
        retireValid = 1'b1;
        retireIdx   = idx[2:0];
        stepCycle();
        retireValid = 1'b0;
        for (int i = 0; i < mIdx.size(); i++) begin
            if (mIdx[i] == idx) begin
                mRetired[i] = 1'b1;
            end
        end
    endtask

    task automatic retireAll();
        for (int i = 0; i < mIdx.size(); i++) begin
            if (!mRetired[i]) begin
                retireStore(mIdx[i]);
            end
        end
    endtask

    // Flush pulse drops every unretired store from the model
    task automatic pulseFlush();
        flush = 1'b1;
        stepCycle();
        flush = 1'b0;
        for (int i = mIdx.size() - 1; i >= 0; i--) begin
            if (!mRetired[i]) begin
                mPaddr.delete(i);
                mSize.delete(i);
                mData.delete(i);
                mIdx.delete(i);
                mRetired.delete(i);
            end
        end
    endtask

    // D-cache responder expecting the oldest retired store
    task automatic serveRequest(input int holdCycles);
        int waited;
        waited = 0;
        while (!dcReqValid && waited < waitBound) begin
            stepCycle();
            waited++;
        end
        if (!dcReqValid) begin
            reportError("no D-cache request appeared within the wait bound");
            return;
        end
        if (mPaddr.size() == 0) begin
            reportError("D-cache request with no store left in the model");
            return;
        end
        for (int c = 0; c <= holdCycles; c++) begin
            checkValue("dcReqValid", 1'b1, dcReqValid);
            checkValue("dcReqPaddr", mPaddr[0], dcReqPaddr);
            checkValue("dcReqSize", mSize[0], dcReqSize);
            checkValue("dcReqData", mData[0], dcReqData);
            if (c < holdCycles) begin
                stepCycle();
            end
        end
        dcDone = 1'b1;
        stepCycle();
        dcDone = 1'b0;
        checkValue("dcReqValid after done", 1'b0, dcReqValid);
        mPaddr.delete(0);
        mSize.delete(0);
        mData.delete(0);
        mIdx.delete(0);
        mRetired.delete(0);
    endtask

    // Killed entries are skipped with no request
    task automatic waitForEmpty();
        int waited;
        waited = 0;
        while (usedEntries != 0 && waited < waitBound) begin
            if (dcReqValid) begin
                reportError("D-cache request while skipping killed entries");
            end
            stepCycle();
            waited++;
        end
        checkValue("usedEntries", 0, usedEntries);
        checkValue("freeEntries", sqDepth, freeEntries);
    endtask

    // Expected bytes from the youngest covering store
    task automatic checkLoad(input logic [paddrWidth-1:0] paddr, input logic [7:0] mask);
        logic [7:0]  expMatch;
        logic [63:0] expData;
        logic [63:0] laneMask;
        int          off;
        int          len;
        expMatch = '0;
        expData  = '0;
        for (int i = 0; i < mPaddr.size(); i++) begin
            off = mPaddr[i][2:0];
            len = 1 << mSize[i];
            for (int b = 0; b < laneBytes; b++) begin
                if (mPaddr[i][paddrWidth-1:3] == paddr[paddrWidth-1:3] && mask[b] &&
                    b >= off && b < off + len) begin
                    expMatch[b]        = 1'b1;
                    expData[b*8 +: 8]  = mData[i][(b - off)*8 +: 8];
                end
            end
        end
        for (int b = 0; b < laneBytes; b++) begin
            laneMask[b*8 +: 8] = {8{expMatch[b]}};
        end
        ldValid    = 1'b1;
        ldPaddr    = paddr;
        ldByteMask = mask;
        #1;
        checkValue("ldRespValid", 1'b1, ldRespValid);
        checkValue("ldMatchMask", expMatch, ldMatchMask);
        checkValue("ldData", expData, ldData & laneMask);
        ldValid = 1'b0;
    endtask

    //********************
    // Tests
    //********************
    task automatic testReset();
        int errorsBefore;
        errorsBefore = errorCount;
        curTest = "reset";
        checkValue("dcReqValid", 1'b0, dcReqValid);
        checkValue("freeEntries", sqDepth, freeEntries);
        checkValue("usedEntries", 0, usedEntries);
        checkValue("sqIndex", 0, sqIndex);
        endTest(errorsBefore);
    endtask

    task automatic testBackPressure();
        int errorsBefore;
        errorsBefore = errorCount;
        curTest = "backPressure";
        dcReady = 1'b0;
        writeStore(56'h00_0040_1230_0004, sizeWord, {32'h0, $random(seed)});
        checkValue("usedEntries", 1, usedEntries);
        retireStore(mIdx[0]);
        // Nothing may go out while the cache is not ready
        repeat (10) begin
            stepCycle();
            if (dcReqValid) begin
                reportError("D-cache request while dcReady was low");
            end
        end
        dcReady = 1'b1;
        serveRequest(3);
        checkValue("freeEntries", sqDepth, freeEntries);
        endTest(errorsBefore);
    endtask

    task automatic testForward();
        int errorsBefore;
        errorsBefore = errorCount;
        curTest = "forward";
        writeStore(56'h00_0000_0012_3450, sizeDouble, {$random(seed), $random(seed)});
        writeStore(56'h00_0000_0012_3455, sizeByte, {56'h0, 8'($random(seed))});
        checkLoad(56'h00_0000_0012_3450, 8'hff);
        checkValue("full mask match", 8'hff, ldMatchMask);
        checkLoad(56'h00_0000_0012_3450, 8'h30);
        checkLoad(56'h00_0000_0012_3458, 8'hff);
        checkValue("other doubleword match", 8'h00, ldMatchMask);
        // Clear the unretired pair for the next test
        pulseFlush();
        waitForEmpty();
        endTest(errorsBefore);
    endtask

    task automatic testFlush();
        int errorsBefore;
        int reqBefore;
        errorsBefore = errorCount;
        reqBefore    = reqCount;
        curTest = "flush";
        writeStore(56'h00_0000_0000_7000, sizeWord, {32'h0, $random(seed)});
        writeStore(56'h00_0000_0000_7108, sizeDouble, {$random(seed), $random(seed)});
        writeStore(56'h00_0000_0000_710a, sizeHalf, {48'h0, 16'($random(seed))});
        retireStore(mIdx[0]);
        pulseFlush();
        checkLoad(56'h00_0000_0000_7108, 8'hff);
        checkValue("killed match", 8'h00, ldMatchMask);
        serveRequest(2);
        waitForEmpty();
        checkValue("request count", 1, reqCount - reqBefore);
        endTest(errorsBefore);
    endtask

    task automatic testWrapOrder();
        int errorsBefore;
        errorsBefore = errorCount;
        curTest = "wrapOrder";
        // Stalled write is refused
        wrValid = 1'b1;
        stall   = 1'b1;
        stepCycle();
        wrValid = 1'b0;
        stall   = 1'b0;
        checkValue("sqIndex after stall", modelTail, sqIndex);
        checkValue("usedEntries after stall", 0, usedEntries);
        repeat (sqDepth) writeRandomStore();
        checkValue("freeEntries when full", 0, freeEntries);
        retireAll();
        repeat (sqDepth) serveRequest(1);
        repeat (4) writeRandomStore();
        retireAll();
        repeat (4) serveRequest(2);
        checkValue("sqIndex after wrap", modelTail, sqIndex);
        waitForEmpty();
        endTest(errorsBefore);
    endtask

    initial begin
        rst         = 1'b1;
        wrValid     = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        wrPaddr     = '0;
        wrSize      = sizeByte;
        wrData      = '0;
        retireValid = 1'b0;
        retireIdx   = '0;
        ldValid     = 1'b0;
        ldPaddr     = '0;
        ldByteMask  = '0;
        dcReady     = 1'b0;
        dcDone      = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        reqCount    = 0;
        modelTail   = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        testReset();
        testBackPressure();
        testForward();
        testFlush();
        testWrapOrder();
        $display("Summary: %0d tests run, %0d with errors, %0d failed checks",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- storeQueue.f
hw/storeQueuePkg.sv
hw/storeAlloc.sv
hw/storeEntries.sv
hw/storeDrain.sv
hw/loadForward.sv
hw/storeQueue.sv
tb/tbStoreQueue.sv

//--- run.sh
#!/bin/sh
# Build and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module tbStoreQueue \
    -Mdir obj_dir -o simStoreQueue -f storeQueue.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simStoreQueue > "$logFile" 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see $logFile"
    exit 1
fi
cat "$logFile"

if grep -q "TESTS FAILED" "$logFile"; then
    echo "Simulation reported failures"
    exit 1
fi
exit 0
